// File: conv_num_pkg.sv
package conv_num_pkg;

	//////////////////////////////////////////////////////////////////////
	// word widths of the datapath
	//////////////////////////////////////////////////////////////////////

	localparam int pix_w = 16; // image sample, signed fixed point
	localparam int wgt_w = 16; // kernel weight, signed fixed point
	localparam int acc_w = 32; // product and running sum
	localparam int ofm_w = 16; // rescaled output pixel

	// field split of an accumulator word
	localparam int guard_w = 2;  // headroom above the kept magnitude
	localparam int mag_w   = 15; // magnitude kept in the output
	localparam int frac_w  = 14; // product scale, dropped on rescale

	// sign | guard | mag | frac, msb first
	typedef struct packed {
		logic               sign;
		logic [guard_w-1:0] guard; // not saturated, just dropped
		logic [mag_w-1:0]   mag;
		logic [frac_w-1:0]  frac;
	} acc_fields_t;

	// one 32 bit sum, seen as a number by the adder
	// and as bit fields by relu and rescale
	typedef union packed {
		logic signed [acc_w-1:0] raw; // sum plus bias
		acc_fields_t             f;   // decoded view
	} acc_word_u;

	// pixel and weight each carry 7 fraction bits,
	// so a product lands on frac_w fraction bits
	// and mag reads the integer part of the sum

endpackage

// File: conv_mem_pkg.sv
package conv_mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// rom geometry and synthetic contents
	//////////////////////////////////////////////////////////////////////

	localparam int img_aw = 18; // image rom, widest address in the design
	localparam int ker_aw = 5;  // kernel rom, one word per tap

	// what a rom instance holds
	typedef enum logic [1:0] {
		pixels,
		weights,
		biases
	} rom_kind_e;

	// pixel: integer part -3..7 with a little fraction, 7 fraction bits
	function automatic logic signed [conv_num_pkg::pix_w-1:0] pixel_val(input int addr);
		int k;
		k = (addr * 7 + 3) % 11 - 3; // mostly positive
		return conv_num_pkg::pix_w'(k * 128 + (addr % 4) * 16);
	endfunction

	// weight: even output channels lean positive, odd ones negative
	// so that both relu branches are hit
	function automatic logic signed [conv_num_pkg::wgt_w-1:0] weight_val(input int oc,
			input int tap);
		int w;
		w = (tap * 3 + oc * 5) % 9 - 4;
		if (oc % 2 == 0)
			w = w + 2;
		else
			w = w - 2;
		return conv_num_pkg::wgt_w'(w * 128); // 7 fraction bits
	endfunction

	// bias given on the product scale, 14 fraction bits
	function automatic logic signed [conv_num_pkg::acc_w-1:0] bias_val(input int oc);
		int b;
		b = (oc % 3 - 1) * 24; // -24, 0 or +24
		return conv_num_pkg::acc_w'(b * (1 << conv_num_pkg::frac_w));
	endfunction

endpackage

// File: conv_rom.sv
`timescale 1ns/1ps

module conv_rom #(
	parameter conv_mem_pkg::rom_kind_e KIND = conv_mem_pkg::pixels,
	parameter WIDTH = 16,
	parameter DEPTH = 300,
	parameter LANES = 1
) (
	input  logic [conv_mem_pkg::img_aw-1:0] addr,
	output logic [LANES-1:0][WIDTH-1:0]     data
);

	localparam int AW = conv_mem_pkg::img_aw;
	localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // index bits

	logic [LANES-1:0][WIDTH-1:0] mem [DEPTH]; // constant table

	// one word of the table, lane l at address a
	function automatic logic [WIDTH-1:0] word_at(input int a, input int l);
		case (KIND)
			conv_mem_pkg::pixels:  return WIDTH'(conv_mem_pkg::pixel_val(a));
			conv_mem_pkg::weights: return WIDTH'(conv_mem_pkg::weight_val(l, a)); // a is tap
			default:               return WIDTH'(conv_mem_pkg::bias_val(l));
		endcase
	endfunction

	// table filled at elaboration, each word a constant
	for (genvar a = 0; a < DEPTH; a++) begin : g_word
		for (genvar l = 0; l < LANES; l++) begin : g_lane
			assign mem[a][l] = word_at(a, l);
		end
	end

	// out of range reads give zero, e.g. the idle tap code
	assign data = (addr < AW'(DEPTH)) ? mem[addr[IW-1:0]] : '0;

endmodule

// File: tap_sequencer.sv
`timescale 1ns/1ps

module tap_sequencer #(
	parameter WOUT       = 4,
	parameter CHIN       = 3,
	parameter KERNEL_DIM = 3
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       conv_en,
	output logic [4:0] tap,
	output logic       win_clr,
	output logic       conv_sample,
	output logic       conv_end
);

	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * CHIN; // 27 taps per window
	localparam int NPOS = WOUT * WOUT;                    // output positions
	localparam int PW   = (NPOS > 1) ? $clog2(NPOS) : 1;

	// tap code outside 0..TAPS-1, no mac work in that cycle
	localparam logic [4:0] TAP_IDLE = 5'h1f;

	logic [4:0]    step; // next step to issue, TAPS is the sample step
	logic [PW-1:0] pos;  // samples issued so far
	logic          done; // last sample issued
	logic          run;

	assign run = conv_en && !done; // pause on conv_en low, freeze when done

	//////////////////////////////////////////////////////////////////////
	// step counter, outputs registered one cycle ahead of use
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			step        <= '0;
			tap         <= TAP_IDLE;
			win_clr     <= 1'b0;
			conv_sample <= 1'b0;
			pos         <= '0;
			done        <= 1'b0;
		end else if (run) begin
			win_clr <= (step == 5'd0); // first tap of the window
			if (step == 5'(TAPS)) begin
				// sample step, sums are complete now
				tap         <= TAP_IDLE;
				conv_sample <= 1'b1;
				step        <= '0;
				pos         <= pos + 1'b1;
				if (pos == PW'(NPOS - 1))
					done <= 1'b1; // that was the last position
			end else begin
				tap         <= step;
				conv_sample <= 1'b0;
				step        <= step + 1'b1;
			end
		end else begin
			// paused or finished, step and pos hold
			tap         <= TAP_IDLE;
			win_clr     <= 1'b0;
			conv_sample <= 1'b0;
		end
	end

	// end level trails the last sample by one cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			conv_end <= 1'b0;
		else
			conv_end <= done; // sticky until reset
	end

endmodule

// File: window_addr_gen.sv
`timescale 1ns/1ps

module window_addr_gen #(
	parameter W_IN       = 10,
	parameter WOUT       = 4,
	parameter STRIDE     = 2,
	parameter KERNEL_DIM = 3
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [4:0]                      tap,
	input  logic                            win_clr,
	input  logic                            conv_sample,
	output logic [conv_mem_pkg::img_aw-1:0] img_addr,
	output logic [conv_mem_pkg::ker_aw-1:0] ker_addr
);

	localparam int AW    = conv_mem_pkg::img_aw;
	localparam int KK    = KERNEL_DIM * KERNEL_DIM; // taps per channel
	localparam int PLANE = W_IN * W_IN;             // one channel plane
	localparam int OW    = $clog2(W_IN) + 1;        // origin coordinate bits
	localparam int CW    = $clog2(WOUT + 1);        // window count bits

	logic [OW-1:0] row_org; // top row of the current window
	logic [OW-1:0] col_org; // left column of the current window
	logic [CW-1:0] col_cnt; // windows begun in this output row
	logic [4:0]    ch;      // channel of this tap
	logic [4:0]    kr;      // kernel row
	logic [4:0]    kc;      // kernel column

	//////////////////////////////////////////////////////////////////////
	// window origin
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row_org <= '0;
			col_org <= '0;
			col_cnt <= '0;
		end else if (win_clr) begin
			col_cnt <= col_cnt + 1'b1; // one more window started in the row
		end else if (conv_sample) begin
			if (col_cnt == CW'(WOUT)) begin
				// row done, go STRIDE rows down and back to column 0
				col_cnt <= '0;
				col_org <= '0;
				row_org <= row_org + OW'(STRIDE);
			end else begin
				col_org <= col_org + OW'(STRIDE); // next window in the row
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// tap decode, order is channel then kernel row then kernel column
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ch = tap / 5'(KK);
		kr = (tap % 5'(KK)) / 5'(KERNEL_DIM);
		kc = tap % 5'(KERNEL_DIM);
	end

	// ch*W_IN^2 + (row_org + kr)*W_IN + col_org + kc
	assign img_addr = AW'(ch) * AW'(PLANE)
		+ (AW'(row_org) + AW'(kr)) * AW'(W_IN)
		+ AW'(col_org) + AW'(kc);

	assign ker_addr = tap; // kernel rom holds one word per tap

endmodule

// File: conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           clr,
	input  logic                           en,
	input  logic [conv_num_pkg::pix_w-1:0] pix,
	input  logic [conv_num_pkg::wgt_w-1:0] ker,
	output logic [conv_num_pkg::acc_w-1:0] acc
);

	logic signed [conv_num_pkg::acc_w-1:0] prod; // full 32 bit product

	// signed 16x16, operands sign extended to 32
	assign prod = $signed(pix) * $signed(ker);

	//////////////////////////////////////////////////////////////////////
	// accumulate one window
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (en) begin
			if (clr)
				acc <= prod;       // first tap restarts the sum
			else
				acc <= acc + prod; // wraps, no saturation
		end
		// en low in the sample cycle and while paused, sum holds
	end

endmodule

// File: ofm_stage.sv
`timescale 1ns/1ps

module ofm_stage #(
	parameter DSP_NO = 4
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       conv_sample,
	input  logic [DSP_NO-1:0][conv_num_pkg::acc_w-1:0] acc,
	input  logic [DSP_NO-1:0][conv_num_pkg::acc_w-1:0] bias,
	output logic [DSP_NO-1:0][conv_num_pkg::ofm_w-1:0] ofm
);

	conv_num_pkg::acc_word_u                    sum [DSP_NO]; // biased sums
	logic [DSP_NO-1:0][conv_num_pkg::ofm_w-1:0] ofm_d;        // next outputs

	//////////////////////////////////////////////////////////////////////
	// bias, relu, rescale
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < DSP_NO; i++) begin
			sum[i].raw = $signed(acc[i]) + $signed(bias[i]);
			if (sum[i].f.sign)
				ofm_d[i] = '0; // relu
			else
				ofm_d[i] = {1'b0, sum[i].f.mag}; // guard and frac dropped
		end
	end

	// outputs move only on the sample pulse
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			ofm <= '0;
		else if (conv_sample)
			ofm <= ofm_d; // valid from next cycle until next sample
	end

endmodule

// File: conv_layer.sv
`timescale 1ns/1ps

module conv_layer #(
	parameter W_IN       = 10,
	parameter WOUT       = 4,
	parameter STRIDE     = 2,
	parameter CHIN       = 3,
	parameter KERNEL_DIM = 3,
	parameter DSP_NO     = 4
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       conv_en,
	output logic                                       conv_sample,
	output logic                                       conv_end,
	output logic [DSP_NO-1:0][conv_num_pkg::ofm_w-1:0] ofm
);

	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * CHIN;

	logic [4:0]                                 tap;
	logic                                       win_clr;
	logic                                       mac_en;    // a real tap this cycle
	logic [conv_mem_pkg::img_aw-1:0]            img_addr;
	logic [conv_mem_pkg::ker_aw-1:0]            ker_addr;
	logic [0:0][conv_num_pkg::pix_w-1:0]        pix_word;  // shared pixel stream
	logic [DSP_NO-1:0][conv_num_pkg::wgt_w-1:0] ker_word;  // one weight per channel
	logic [DSP_NO-1:0][conv_num_pkg::acc_w-1:0] bias_word;
	logic [DSP_NO-1:0][conv_num_pkg::acc_w-1:0] acc_bus;   // window sums

	//////////////////////////////////////////////////////////////////////
	// control and addressing
	//////////////////////////////////////////////////////////////////////

	tap_sequencer #(.WOUT(WOUT), .CHIN(CHIN), .KERNEL_DIM(KERNEL_DIM)) u_seq (
		.clk(clk),
		.rst(rst),
		.conv_en(conv_en),
		.tap(tap),
		.win_clr(win_clr),
		.conv_sample(conv_sample),
		.conv_end(conv_end)
	);

	window_addr_gen #(.W_IN(W_IN), .WOUT(WOUT), .STRIDE(STRIDE),
		.KERNEL_DIM(KERNEL_DIM)) u_addr (
		.clk(clk),
		.rst(rst),
		.tap(tap),
		.win_clr(win_clr),
		.conv_sample(conv_sample),
		.img_addr(img_addr),
		.ker_addr(ker_addr)
	);

	assign mac_en = (tap < 5'(TAPS)); // idle and sample codes fall outside

	//////////////////////////////////////////////////////////////////////
	// roms
	//////////////////////////////////////////////////////////////////////

	conv_rom #(.KIND(conv_mem_pkg::pixels), .WIDTH(conv_num_pkg::pix_w),
		.DEPTH(CHIN * W_IN * W_IN), .LANES(1)) u_img_rom (
		.addr(img_addr),
		.data(pix_word)
	);

	conv_rom #(.KIND(conv_mem_pkg::weights), .WIDTH(conv_num_pkg::wgt_w),
		.DEPTH(TAPS), .LANES(DSP_NO)) u_ker_rom (
		.addr({{(conv_mem_pkg::img_aw - conv_mem_pkg::ker_aw){1'b0}}, ker_addr}),
		.data(ker_word)
	);

	conv_rom #(.KIND(conv_mem_pkg::biases), .WIDTH(conv_num_pkg::acc_w),
		.DEPTH(1), .LANES(DSP_NO)) u_bias_rom (
		.addr('0), // single row of biases
		.data(bias_word)
	);

	//////////////////////////////////////////////////////////////////////
	// mac bank, one unit per output channel, then output stage
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < DSP_NO; i++) begin : g_mac
		conv_mac u_mac (
			.clk(clk),
			.rst(rst),
			.clr(win_clr),
			.en(mac_en),
			.pix(pix_word[0]),
			.ker(ker_word[i]),
			.acc(acc_bus[i])
		);
	end

	ofm_stage #(.DSP_NO(DSP_NO)) u_ofm (
		.clk(clk),
		.rst(rst),
		.conv_sample(conv_sample),
		.acc(acc_bus),
		.bias(bias_word),
		.ofm(ofm)
	);

endmodule

// File: conv_layer_sva.sv
`timescale 1ns/1ps

module conv_layer_sva (
	input logic clk,
	input logic rst,
	input logic win_clr,
	input logic conv_sample,
	input logic conv_end
);

	//////////////////////////////////////////////////////////////////////
	// sequencer pulse and end rules
	//////////////////////////////////////////////////////////////////////

	// window start and sample step are separate states of the counter
	a_clr_vs_sample: assert property (@(posedge clk) disable iff (!rst)
		!(win_clr && conv_sample))
		else $error("win_clr and conv_sample high in the same cycle");

	// frozen once the last position is out
	a_no_sample_after_end: assert property (@(posedge clk) disable iff (!rst)
		conv_end |-> !conv_sample)
		else $error("conv_sample seen while conv_end is high");

	a_end_holds: assert property (@(posedge clk) disable iff (!rst)
		conv_end |=> conv_end) // only reset clears it
		else $error("conv_end fell without a reset");

endmodule

// every sequencer instance gets the checks
bind tap_sequencer conv_layer_sva u_sva (
	.clk(clk),
	.rst(rst),
	.win_clr(win_clr),
	.conv_sample(conv_sample),
	.conv_end(conv_end)
);

// File: conv_layer_tb.sv
`timescale 1ns/1ps

module conv_layer_tb;

	localparam int W_IN       = 10;
	localparam int WOUT       = 4;
	localparam int STRIDE     = 2;
	localparam int CHIN       = 3;
	localparam int KERNEL_DIM = 3;
	localparam int DSP_NO     = 4;
	localparam int NPOS       = WOUT * WOUT;                        // output positions
	localparam int PERIOD_EN  = KERNEL_DIM * KERNEL_DIM * CHIN + 1; // taps plus sample step
	localparam int RUN_CYC    = PERIOD_EN * NPOS;                   // enabled cycles, whole layer
	localparam int IDLE_CYC   = 12;
	localparam int POST_CYC   = 40;  // cycles watched after conv_end
	localparam int NTESTS     = 4;

	logic                                       clk;
	logic                                       rst;
	logic                                       conv_en;
	logic                                       conv_sample;
	logic                                       conv_end;
	logic [DSP_NO-1:0][conv_num_pkg::ofm_w-1:0] ofm;

	int   pause_len [RUN_CYC]; // conv_en low cycles inserted before enabled cycle i
	int   pause_total;
	int   cycle_limit = RUN_CYC + 200;
	int   cycles;
	int   seed_val;
	int   idx;
	int   cur_test;
	int   test_err [NTESTS];
	int   n_pass;
	int   n_checks;
	int   n_err;
	int   n_samples;       // conv_sample pulses seen so far
	int   en_cnt;          // enabled cycles since the last pulse
	int   check_pos;       // raster position waiting for its compare
	int   n_zero;          // lanes the dut clamped to zero where relu should
	int   n_pos;           // lanes the dut gave the right magnitude
	logic check_pending;
	logic last_was_sample;
	logic end_seen;

	conv_layer #(.W_IN(W_IN), .WOUT(WOUT), .STRIDE(STRIDE), .CHIN(CHIN),
		.KERNEL_DIM(KERNEL_DIM), .DSP_NO(DSP_NO)) dut (
		.clk(clk),
		.rst(rst),
		.conv_en(conv_en),
		.conv_sample(conv_sample),
		.conv_end(conv_end),
		.ofm(ofm)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period

	//////////////////////////////////////////////////////////////////////
	// reference model and reporting helpers
	//////////////////////////////////////////////////////////////////////

	// one output lane: 27 taps, bias, relu, keep the integer magnitude
	function automatic logic [conv_num_pkg::ofm_w-1:0] expected_ofm(input int orow,
			input int ocol, input int oc);
		logic signed [conv_num_pkg::acc_w-1:0] sum;
		logic signed [conv_num_pkg::acc_w-1:0] p;
		logic signed [conv_num_pkg::acc_w-1:0] w;
		conv_num_pkg::acc_word_u               word;
		int                                    addr;
		sum = '0;
		for (int c = 0; c < CHIN; c++)
			for (int kr = 0; kr < KERNEL_DIM; kr++)
				for (int kc = 0; kc < KERNEL_DIM; kc++) begin
					addr = c * W_IN * W_IN + (orow * STRIDE + kr) * W_IN + ocol * STRIDE + kc;
					p    = conv_mem_pkg::pixel_val(addr);
					w    = conv_mem_pkg::weight_val(oc, (c * KERNEL_DIM + kr) * KERNEL_DIM + kc);
					sum  = sum + p * w; // 32 bit wrap, same as a plain register
				end
		word.raw = sum + conv_mem_pkg::bias_val(oc);
		if (word.f.sign)
			return '0;                 // negative window
		return {1'b0, word.f.mag};     // guard and frac bits fall away
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
			n_err++;
			test_err[cur_test]++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("%0t: %s", $time, what);
		n_err++;
		test_err[cur_test]++;
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s: %s, %0d errors", cur_test + 1, name,
			(test_err[cur_test] == 0) ? "pass" : "fail", test_err[cur_test]);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1; // inputs move just after the edge
	endtask

	// run limit, counted in clock cycles
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: layer did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare process, samples on the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic [conv_num_pkg::ofm_w-1:0] exp_v;
		if (check_pending) begin
			// ofm was loaded on the edge that closed the sample cycle
			for (int l = 0; l < DSP_NO; l++) begin
				exp_v = expected_ofm(check_pos / WOUT, check_pos % WOUT, l);
				if (ofm[l] === exp_v) begin
					// tally the relu branch the dut got right
					if (exp_v == '0)
						n_zero++;
					else
						n_pos++;
				end
				check_value($sformatf("ofm[%0d]", l), exp_v, ofm[l]);
			end
			check_pending = 1'b0;
		end
		if (conv_sample) begin
			check_value("enabled cycles per sample", PERIOD_EN, en_cnt);
			if (n_samples >= NPOS) begin
				note_failure("conv_sample pulsed after the last output position");
			end else begin
				check_pos     = n_samples; // raster order
				check_pending = 1'b1;
			end
			n_samples++;
			en_cnt = 0;
		end
		if (conv_end && !end_seen) begin
			end_seen = 1'b1;
			check_value("conv_sample before conv_end", 1, last_was_sample);
			check_value("samples at conv_end", NPOS, n_samples);
		end
		if (conv_en)
			en_cnt++; // seen by the sequencer on the next rising edge
		last_was_sample = conv_sample;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed_val        = $urandom(29238);
		rst             = 1'b0;
		conv_en         = 1'b0;
		check_pending   = 1'b0;
		last_was_sample = 1'b0;
		end_seen        = 1'b0;
		// pause schedule, about one enabled cycle in twelve gets a gap of 1..6
		for (int i = 0; i < RUN_CYC; i++) begin
			pause_len[i] = ($urandom % 12 == 0) ? 1 + $urandom % 6 : 0;
			pause_total += pause_len[i];
		end
		cycle_limit = RUN_CYC + pause_total + 200;
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;

		cur_test = 0; // quiet while conv_en stays low
		repeat (IDLE_CYC) begin
			@(negedge clk);
			check_value("conv_sample", 0, conv_sample);
			check_value("conv_end", 0, conv_end);
			for (int l = 0; l < DSP_NO; l++)
				check_value($sformatf("ofm[%0d]", l), 0, ofm[l]);
		end
		finish_test("idle after reset");

		cur_test = 1; // whole layer with conv_en gaps
		next_cycle();
		idx = 0;
		while (!conv_end) begin
			if (idx < RUN_CYC && pause_len[idx] != 0) begin
				conv_en = 1'b0;
				repeat (pause_len[idx]) next_cycle();
			end
			conv_en = 1'b1;
			next_cycle();
			idx++;
		end
		@(negedge clk); // last position compared here
		next_cycle();
		finish_test("raster values with pauses");

		cur_test = 2;
		if (n_zero == 0)
			note_failure("no output lane was correctly clamped to zero by relu");
		if (n_pos == 0)
			note_failure("no output lane came out with the correct positive value");
		finish_test("relu both branches");

		cur_test = 3; // conv_en still high, layer must stay frozen
		repeat (POST_CYC) begin
			@(negedge clk);
			check_value("conv_end", 1, conv_end);
			check_value("conv_sample", 0, conv_sample);
		end
		check_value("sample count", NPOS, n_samples);
		finish_test("end flag and sample count");

		for (int t = 0; t < NTESTS; t++)
			if (test_err[t] == 0)
				n_pass++;
		$display("tests %0d, passed %0d, checks %0d, errors %0d", NTESTS, n_pass, n_checks,
			n_err);
		if (n_err == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sources.f
conv_num_pkg.sv
conv_mem_pkg.sv
conv_rom.sv
tap_sequencer.sv
window_addr_gen.sv
conv_mac.sv
ofm_stage.sv
conv_layer.sv
conv_layer_sva.sv
conv_layer_tb.sv

// File: run.sh
#!/bin/sh
# build and run the conv layer testbench, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module conv_layer_tb \
	-o conv_layer_sim && ./obj_dir/conv_layer_sim > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
grep -q "%Error" sim.log && echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
